//--- source/adc_params.svh
// Widths, register offsets, base address and output credit depth for the ADC channel
`ifndef ADC_PARAMS_SVH
`define ADC_PARAMS_SVH

// Datapath and bus widths
`define ADC_DATA_WIDTH 16
`define ADC_BUS_WIDTH 32
`define ADC_ADDR_WIDTH 32

// Register window
`define ADC_BASE_ADDRESS 32'h43C0_0000

// Threshold registers, slow window in the upper half, fast in the lower half
`define ADC_REG_THRESH_0 32'h00
`define ADC_REG_THRESH_1 32'h04
`define ADC_REG_THRESH_2 32'h08
`define ADC_REG_THRESH_3 32'h0C

`define ADC_REG_CALIB 32'h10
`define ADC_REG_CONTROL 32'h14
`define ADC_REG_STATUS 32'h18

// Output slots the consumer holds
`define ADC_CREDITS 4

`endif

//--- source/adc_bus_pkg.sv
// Register bus request and response structs and the register word decode union
`include "adc_params.svh"

package adc_bus_pkg;

    typedef struct packed {
        logic                       write_strobe;
        logic                       read_strobe;
        logic [`ADC_ADDR_WIDTH-1:0] address;
        logic [`ADC_BUS_WIDTH-1:0]  write_data;
    } bus_request_t;

    typedef struct packed {
        logic                      ready;
        logic                      read_valid;
        logic [`ADC_BUS_WIDTH-1:0] read_data;
    } bus_response_t;

    // Threshold register view
    typedef struct packed {
        logic signed [15:0] slow;
        logic signed [15:0] fast;
    } threshold_pair_t;

    // Control register view
    typedef struct packed {
        logic [7:0] decimation_ratio;
        logic [5:0] reserved;
        logic       disable_fault;
        logic       clear_fault;
        logic [7:0] slow_fault_threshold;
        logic [2:0] shift;
        logic [1:0] clear_latch;
        logic [1:0] latch_mode;
        logic       gain_enable;
    } control_word_t;

    typedef union packed {
        logic [`ADC_BUS_WIDTH-1:0] word;
        threshold_pair_t           pair;
        control_word_t             control;
    } register_word_u;

endpackage

//--- source/adc_data_pkg.sv
// Sample, trip, window and configuration structs shared by the datapath blocks
`include "adc_params.svh"

package adc_data_pkg;

    typedef struct packed {
        logic                             valid;
        logic signed [`ADC_DATA_WIDTH-1:0] value;
    } sample_t;

    // Index 0 is the fast window, index 1 the slow one
    typedef struct packed {
        logic [1:0] high;
        logic [1:0] low;
    } trip_t;

    typedef struct packed {
        logic signed [`ADC_DATA_WIDTH-1:0] low_falling;
        logic signed [`ADC_DATA_WIDTH-1:0] low_rising;
        logic signed [`ADC_DATA_WIDTH-1:0] high_falling;
        logic signed [`ADC_DATA_WIDTH-1:0] high_rising;
    } window_t;

    // Gain is fixed point, 256 is unity
    typedef struct packed {
        logic signed [`ADC_DATA_WIDTH-1:0] offset;
        logic signed [`ADC_DATA_WIDTH-1:0] gain;
        logic [2:0]                        shift;
        logic                              gain_enable;
    } calib_config_t;

    typedef struct packed {
        window_t [1:0] window;
        logic [1:0]    latch_mode;
        logic [1:0]    clear_latch;
    } comp_config_t;

endpackage

//--- source/adc_control_unit.sv
// Register bus decoder, configuration register bank, write sequencer and status readback
`include "adc_params.svh"

module adc_control_unit
    import adc_bus_pkg::*, adc_data_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  bus_request_t  bus_in,
    output bus_response_t bus_out,
    input  trip_t         trips,
    input  logic          fault,
    input  logic          overrun,
    output calib_config_t calib_config,
    output comp_config_t  comp_config,
    output logic [7:0]    decimation_ratio,
    output logic [7:0]    slow_fault_threshold,
    output logic          clear_fault,
    output logic          disable_fault,
    output logic          pipeline_flush
);

    typedef enum logic [1:0] {wait_state, act_state, flush_state} state_t;

    state_t                     state;
    logic                       ready;
    logic                       read_valid;
    logic [`ADC_BUS_WIDTH-1:0]  read_data;
    logic [`ADC_ADDR_WIDTH-1:0] bus_offset;
    logic [`ADC_ADDR_WIDTH-1:0] latched_offset;
    register_word_u             latched_word;
    logic [`ADC_BUS_WIDTH-1:0]  readback;
    logic [`ADC_BUS_WIDTH-1:0]  status_word;
    register_word_u             thresh_reg [4];
    logic [`ADC_BUS_WIDTH-1:0]  calib_reg;
    register_word_u             control_reg;

    assign bus_out = '{ready: ready, read_valid: read_valid, read_data: read_data};
    assign bus_offset = bus_in.address - `ADC_BASE_ADDRESS;
    assign status_word = `ADC_BUS_WIDTH'({trips, overrun, fault});
    assign pipeline_flush = (state == flush_state);

    always_comb begin
        case (bus_offset)
            `ADC_REG_THRESH_0: readback = thresh_reg[0].word;
            `ADC_REG_THRESH_1: readback = thresh_reg[1].word;
            `ADC_REG_THRESH_2: readback = thresh_reg[2].word;
            `ADC_REG_THRESH_3: readback = thresh_reg[3].word;
            `ADC_REG_CALIB:    readback = calib_reg;
            `ADC_REG_CONTROL:  readback = control_reg.word;
            `ADC_REG_STATUS:   readback = status_word;
            default:           readback = '0;
        endcase
    end

    // Write capture
    always_ff @(posedge clock) begin
        if (state == wait_state && bus_in.write_strobe) begin
            latched_offset <= bus_offset;
            latched_word <= bus_in.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= wait_state;
            ready <= 1'b1;
            read_valid <= 1'b0;
            read_data <= '0;
            clear_fault <= 1'b0;
            calib_reg <= '0;
            control_reg <= '0;
            for (int i = 0; i < 4; i++) begin
                thresh_reg[i] <= '0;
            end
        end else begin
            read_valid <= 1'b0;
            read_data <= '0;
            clear_fault <= 1'b0;
            case (state)
                wait_state: begin
                    ready <= 1'b1;
                    if (bus_in.write_strobe) begin
                        ready <= 1'b0;
                        state <= act_state;
                    end else if (bus_in.read_strobe) begin
                        ready <= 1'b0;
                        read_valid <= 1'b1;
                        read_data <= readback;
                    end
                end
                act_state: begin
                    // Unknown offsets and status fall through untouched
                    case (latched_offset)
                        `ADC_REG_THRESH_0, `ADC_REG_THRESH_1,
                        `ADC_REG_THRESH_2, `ADC_REG_THRESH_3:
                            thresh_reg[latched_offset[3:2]] <= latched_word;
                        `ADC_REG_CALIB:   calib_reg <= latched_word.word;
                        `ADC_REG_CONTROL: control_reg <= latched_word;
                        default: ;
                    endcase
                    clear_fault <= (latched_offset == `ADC_REG_CONTROL)
                                   && latched_word.control.clear_fault;
                    state <= flush_state;
                end
                flush_state: begin
                    ready <= 1'b1;
                    state <= wait_state;
                end
                default: state <= wait_state;
            endcase
        end
    end

    // Configuration decode
    always_comb begin
        comp_config.window[0] = '{low_falling: thresh_reg[0].pair.fast,
                                  low_rising: thresh_reg[1].pair.fast,
                                  high_falling: thresh_reg[2].pair.fast,
                                  high_rising: thresh_reg[3].pair.fast};
        comp_config.window[1] = '{low_falling: thresh_reg[0].pair.slow,
                                  low_rising: thresh_reg[1].pair.slow,
                                  high_falling: thresh_reg[2].pair.slow,
                                  high_rising: thresh_reg[3].pair.slow};
        comp_config.latch_mode = control_reg.control.latch_mode;
        comp_config.clear_latch = control_reg.control.clear_latch;
        calib_config.offset = calib_reg[15:0];
        calib_config.gain = calib_reg[31:16];
        calib_config.shift = control_reg.control.shift;
        calib_config.gain_enable = control_reg.control.gain_enable;
    end

    assign decimation_ratio = control_reg.control.decimation_ratio;
    assign slow_fault_threshold = control_reg.control.slow_fault_threshold;
    assign disable_fault = control_reg.control.disable_fault;

    // Master must respect ready
    assert property (@(posedge clock) disable iff (!reset)
        !ready |-> !(bus_in.write_strobe || bus_in.read_strobe))
        else $error("bus strobe while ready is low");

    assert property (@(posedge clock) disable iff (!reset)
        $rose(pipeline_flush) |=> !pipeline_flush)
        else $error("pipeline flush longer than one cycle");

endmodule

//--- source/adc_fault_unit.sv
// Protection fault from comparator trips, with arming, slow trip counter and sticky latch
module adc_fault_unit
    import adc_data_pkg::*;
#(
    parameter bit sticky_fault = 1'b0
) (
    input  logic       clock,
    input  logic       reset,
    input  trip_t      trips,
    input  logic       sample_valid,
    input  logic       disable_fault,
    input  logic       clear_fault,
    input  logic [7:0] slow_fault_threshold,
    output logic       fault
);

    generate
        if (!sticky_fault) begin : g_direct
            assign fault = |{trips.high, trips.low};
        end else begin : g_sticky
            logic       armed;
            logic       trip_valid;
            logic       fault_q;
            logic       fast_trip;
            logic       slow_trip;
            logic [7:0] slow_count;
            logic [7:0] threshold;

            assign fast_trip = trips.high[0] | trips.low[0];
            assign slow_trip = trips.high[1] | trips.low[1];
            assign threshold = (slow_fault_threshold == 8'd0) ? 8'd1 : slow_fault_threshold;
            assign fault = fault_q;

            // Arms on the first sample after reset or after disable drops
            always_ff @(posedge clock) begin
                if (!reset || disable_fault) begin
                    armed <= 1'b0;
                end else if (sample_valid) begin
                    armed <= 1'b1;
                end
            end

            // Trips lag the calibrated sample by one cycle
            always_ff @(posedge clock) begin
                if (!reset) begin
                    trip_valid <= 1'b0;
                end else begin
                    trip_valid <= sample_valid;
                end
            end

            always_ff @(posedge clock) begin
                if (!reset || !armed) begin
                    fault_q <= 1'b0;
                    slow_count <= '0;
                end else begin
                    if (!slow_trip) begin
                        slow_count <= '0;
                    end else if (trip_valid && slow_count != 8'hFF) begin
                        slow_count <= slow_count + 8'd1;
                    end
                    if (fast_trip || (slow_trip && trip_valid
                            && {1'b0, slow_count} + 9'd1 >= {1'b0, threshold})) begin
                        fault_q <= 1'b1;
                    end else if (clear_fault && !fast_trip && !slow_trip) begin
                        fault_q <= 1'b0;
                    end
                end
            end
        end
    endgenerate

endmodule

//--- source/adc_calibrator.sv
// Sample calibration with offset, gain, arithmetic shift and saturation
module adc_calibrator
    import adc_data_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          flush,
    input  calib_config_t calib_config,
    input  sample_t       in_sample,
    output sample_t       out_sample
);

    logic signed [16:0] offset_sum;
    logic signed [32:0] product;
    logic signed [32:0] scaled;
    logic signed [15:0] saturated;
    logic [3:0]         shift_total;
    logic               out_valid;
    logic signed [15:0] out_value;

    assign offset_sum = in_sample.value + calib_config.offset;
    assign product = offset_sum * calib_config.gain;
    // Gain is Q8, so the fixed part of the shift is 8
    assign shift_total = 4'd8 + {1'b0, calib_config.shift};
    assign scaled = calib_config.gain_enable ? (product >>> shift_total) : offset_sum;

    always_comb begin
        if (scaled > 33'sd32767) begin
            saturated = 16'sh7FFF;
        end else if (scaled < -33'sd32768) begin
            saturated = 16'sh8000;
        end else begin
            saturated = scaled[15:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_sample.valid && !flush;
        end
    end

    always_ff @(posedge clock) begin
        out_value <= saturated;
    end

    assign out_sample = '{valid: out_valid, value: out_value};

    assert property (@(posedge clock) disable iff (!reset)
        flush |=> !out_sample.valid)
        else $error("calibrated sample valid right after a flush");

endmodule

//--- source/adc_comparators.sv
// Fast and slow hysteresis windows producing high and low trips, with optional latching
module adc_comparators
    import adc_data_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    input  comp_config_t comp_config,
    input  sample_t      in_sample,
    output trip_t        trips
);

    logic [1:0] low_q;
    logic [1:0] high_q;
    logic [1:0] clear_now;

    // A latched trip ignores its release threshold
    function automatic logic next_trip(
        input logic current,
        input logic set_cond,
        input logic release_cond,
        input logic latched
    );
        if (set_cond) begin
            return 1'b1;
        end
        if (!latched && release_cond) begin
            return 1'b0;
        end
        return current;
    endfunction

    // Only latched trips are cleared by a clear bit or a flush
    assign clear_now = comp_config.latch_mode & (comp_config.clear_latch | {2{flush}});

    always_ff @(posedge clock) begin
        if (!reset) begin
            low_q <= '0;
            high_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (clear_now[i]) begin
                    low_q[i] <= 1'b0;
                    high_q[i] <= 1'b0;
                end else if (in_sample.valid) begin
                    low_q[i] <= next_trip(low_q[i],
                        in_sample.value < comp_config.window[i].low_falling,
                        in_sample.value > comp_config.window[i].low_rising,
                        comp_config.latch_mode[i]);
                    high_q[i] <= next_trip(high_q[i],
                        in_sample.value > comp_config.window[i].high_rising,
                        in_sample.value < comp_config.window[i].high_falling,
                        comp_config.latch_mode[i]);
                end
            end
        end
    end

    assign trips = '{high: high_q, low: low_q};

endmodule

//--- source/adc_decimator.sv
// Keep-every-Nth decimation with credit based output flow control and overrun flag
`include "adc_params.svh"

module adc_decimator
    import adc_data_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic [7:0] ratio,
    input  sample_t    in_sample,
    input  logic       credit,
    output sample_t    out_sample,
    output logic       overrun
);

    localparam int credit_width = $clog2(`ADC_CREDITS + 1);

    logic [7:0]              phase;
    logic [7:0]              ratio_used;
    logic [credit_width-1:0] credits;
    logic                    keep;
    logic                    send;
    logic                    out_valid;
    logic signed [15:0]      out_value;

    assign ratio_used = (ratio == 8'd0) ? 8'd1 : ratio;
    assign keep = in_sample.valid && (phase == 8'd0);
    assign send = keep && (credits != '0) && !flush;

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase <= '0;
            credits <= credit_width'(`ADC_CREDITS);
            overrun <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            credits <= credits + credit_width'(credit) - credit_width'(send);
            if (flush) begin
                phase <= '0;
                overrun <= 1'b0;
            end else if (in_sample.valid) begin
                phase <= (phase + 8'd1 >= ratio_used) ? 8'd0 : phase + 8'd1;
                // Kept sample with no slot left
                if (keep && credits == '0) begin
                    overrun <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (keep) begin
            out_value <= in_sample.value;
        end
    end

    assign out_sample = '{valid: out_valid, value: out_value};

    // Consumer must not return more credits than it was given
    assert property (@(posedge clock) disable iff (!reset)
        credits <= credit_width'(`ADC_CREDITS))
        else $error("credit count above the credit depth");

endmodule

//--- source/adc_processing.sv
// ADC channel top level joining the control unit and the conditioning datapath
module adc_processing
    import adc_bus_pkg::*, adc_data_pkg::*;
#(
    parameter bit sticky_fault = 1'b0
) (
    input  logic          clock,
    input  logic          reset,
    input  bus_request_t  bus_in,
    output bus_response_t bus_out,
    input  sample_t       in_sample,
    output sample_t       out_sample,
    input  logic          credit,
    output logic          fault
);

    calib_config_t calib_config;
    comp_config_t  comp_config;
    logic [7:0]    decimation_ratio;
    logic [7:0]    slow_fault_threshold;
    logic          clear_fault;
    logic          disable_fault;
    logic          pipeline_flush;
    sample_t       calibrated;
    trip_t         trips;
    logic          overrun;

    adc_control_unit i_control_unit (
        .clock(clock),
        .reset(reset),
        .bus_in(bus_in),
        .bus_out(bus_out),
        .trips(trips),
        .fault(fault),
        .overrun(overrun),
        .calib_config(calib_config),
        .comp_config(comp_config),
        .decimation_ratio(decimation_ratio),
        .slow_fault_threshold(slow_fault_threshold),
        .clear_fault(clear_fault),
        .disable_fault(disable_fault),
        .pipeline_flush(pipeline_flush)
    );

    adc_calibrator i_calibrator (
        .clock(clock),
        .reset(reset),
        .flush(pipeline_flush),
        .calib_config(calib_config),
        .in_sample(in_sample),
        .out_sample(calibrated)
    );

    adc_comparators i_comparators (
        .clock(clock),
        .reset(reset),
        .flush(pipeline_flush),
        .comp_config(comp_config),
        .in_sample(calibrated),
        .trips(trips)
    );

    adc_fault_unit #(.sticky_fault(sticky_fault)) i_fault_unit (
        .clock(clock),
        .reset(reset),
        .trips(trips),
        .sample_valid(calibrated.valid),
        .disable_fault(disable_fault),
        .clear_fault(clear_fault),
        .slow_fault_threshold(slow_fault_threshold),
        .fault(fault)
    );

    adc_decimator i_decimator (
        .clock(clock),
        .reset(reset),
        .flush(pipeline_flush),
        .ratio(decimation_ratio),
        .in_sample(calibrated),
        .credit(credit),
        .out_sample(out_sample),
        .overrun(overrun)
    );

endmodule

//--- dv/adc_checker.sv
// Response checker comparing read data, output samples and the fault pin against queued values
module adc_checker
    import adc_bus_pkg::*, adc_data_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input bus_response_t bus_out,
    input sample_t       out_sample,
    input logic          fault
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] read_queue [$];
    logic        status_queue [$];
    logic [15:0] sample_queue [$];
    logic [31:0] expected_word;
    logic        status_read;
    logic [15:0] expected_value;
    int          checks = 0;
    int          failures = 0;

    // Status reads also carry the expected fault pin in bit 0
    task automatic expect_read(input logic [31:0] value, input logic is_status);
        read_queue.push_back(value);
        status_queue.push_back(is_status);
    endtask

    task automatic expect_sample(input logic [15:0] value);
        sample_queue.push_back(value);
    endtask

    function automatic int pending();
        return read_queue.size() + sample_queue.size();
    endfunction

    // Drops what is queued so later responses line up again
    task automatic report_problem(input string text);
        failures++;
        $display("%s", text);
        read_queue.delete();
        status_queue.delete();
        sample_queue.delete();
    endtask

    always @(posedge clock) begin
        if (reset) begin
            if (bus_out.read_valid) begin
                if (read_queue.size() == 0) begin
                    report_problem("Read data came back with no read pending");
                end else begin
                    expected_word = read_queue.pop_front();
                    status_read = status_queue.pop_front();
                    checks++;
                    if (bus_out.read_data !== expected_word) begin
                        failures++;
                        $display("CHECK FAILED read_data expected %h got %h",
                                 expected_word, bus_out.read_data);
                    end else begin
                        $display("read_data %h as expected", bus_out.read_data);
                    end
                    if (status_read) begin
                        checks++;
                        if (fault !== expected_word[0]) begin
                            failures++;
                            $display("CHECK FAILED fault expected %h got %h",
                                     expected_word[0], fault);
                        end else begin
                            $display("fault %h as expected", fault);
                        end
                    end
                end
            end else if (bus_out.read_data !== '0) begin
                failures++;
                $display("CHECK FAILED read_data expected %h got %h", 32'h0, bus_out.read_data);
            end
            if (out_sample.valid) begin
                if (sample_queue.size() == 0) begin
                    report_problem("An output sample appeared where none was expected");
                end else begin
                    expected_value = sample_queue.pop_front();
                    checks++;
                    if (out_sample.value !== expected_value) begin
                        failures++;
                        $display("CHECK FAILED out_sample expected %h got %h",
                                 expected_value, out_sample.value);
                    end else begin
                        $display("out_sample %h as expected", out_sample.value);
                    end
                end
            end
            if ($isunknown(fault)) begin
                report_problem("The fault output is unknown after reset");
            end
        end
    end

endmodule

//--- dv/adc_processing_tb.sv
// Testbench top with clock, reset, file driven stimulus, watchdog, DUT and checker instances
`include "adc_params.svh"

module adc_processing_tb
    import adc_bus_pkg::*, adc_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic          clock;
    logic          reset;
    bus_request_t  bus_in;
    bus_response_t bus_out;
    sample_t       in_sample;
    sample_t       out_sample;
    logic          credit;
    logic          fault;
    logic          loaded = 1'b0;
    string         lines [$];

    adc_processing #(.sticky_fault(1'b1)) i_adc_processing (
        .clock(clock),
        .reset(reset),
        .bus_in(bus_in),
        .bus_out(bus_out),
        .in_sample(in_sample),
        .out_sample(out_sample),
        .credit(credit),
        .fault(fault)
    );

    adc_checker i_checker (
        .clock(clock),
        .reset(reset),
        .bus_out(bus_out),
        .out_sample(out_sample),
        .fault(fault)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // A dash stands for an empty column
    function automatic logic [31:0] parse_hex(input string text);
        logic [31:0] value;
        value = '0;
        if (text != "-") begin
            void'($sscanf(text, "%h", value));
        end
        return value;
    endfunction

    task automatic load_stimulus();
        int    fd;
        string line;
        fd = $fopen("dv/adc_stimulus.txt", "r");
        if (fd == 0) begin
            i_checker.report_problem("Stimulus file dv/adc_stimulus.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // Ends on the edge where ready was seen high
    task automatic wait_ready();
        @(posedge clock);
        while (!bus_out.ready) begin
            @(posedge clock);
        end
    endtask

    task automatic wait_for_checker(input int cycles, input string what);
        int waited;
        waited = 0;
        @(negedge clock);
        while (i_checker.pending() != 0 && waited < cycles) begin
            @(negedge clock);
            waited++;
        end
        if (i_checker.pending() != 0) begin
            i_checker.report_problem({"No ", what, " arrived in time"});
        end
    endtask

    task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
        wait_ready();
        bus_in <= '{write_strobe: 1'b1, read_strobe: 1'b0, address: address, write_data: data};
        @(posedge clock);
        bus_in <= '0;
        // Ready drops for the act and flush cycles
        do @(posedge clock); while (!bus_out.ready);
    endtask

    task automatic bus_read(input logic [31:0] address, input logic [31:0] expected);
        wait_ready();
        i_checker.expect_read(expected, address == `ADC_BASE_ADDRESS + `ADC_REG_STATUS);
        bus_in <= '{write_strobe: 1'b0, read_strobe: 1'b1, address: address, write_data: '0};
        @(posedge clock);
        bus_in <= '0;
        wait_for_checker(4, "read response");
    endtask

    task automatic drive_sample(input logic [15:0] value, input logic kept,
                                input logic [15:0] expected);
        @(posedge clock);
        if (kept) begin
            i_checker.expect_sample(expected);
        end
        in_sample <= '{valid: 1'b1, value: value};
        @(posedge clock);
        in_sample <= '{valid: 1'b0, value: value};
        if (kept) begin
            wait_for_checker(4, "output sample");
        end else begin
            // Two cycle pipeline plus the fault register
            repeat (3) @(posedge clock);
        end
    endtask

    task automatic return_credits(input logic [31:0] count);
        repeat (count) begin
            @(posedge clock);
            credit <= 1'b1;
            @(posedge clock);
            credit <= 1'b0;
        end
    endtask

    task automatic run_line(input string line);
        string       op;
        string       arg_text;
        string       data_text;
        string       expect_text;
        int          fields;
        logic [31:0] arg;
        logic [31:0] expected;
        fields = $sscanf(line, "%s %s %s %s", op, arg_text, data_text, expect_text);
        arg = parse_hex(arg_text);
        expected = parse_hex(expect_text);
        if (fields != 4) begin
            i_checker.report_problem({"Malformed stimulus line: ", line});
        end else begin
            case (op)
                "write":  bus_write(arg, parse_hex(data_text));
                "read":   bus_read(arg, expected);
                "sample": drive_sample(arg[15:0], expect_text != "-", expected[15:0]);
                "credit": return_credits(arg);
                default:  i_checker.report_problem({"Unknown operation: ", op});
            endcase
        end
    endtask

    initial begin
        bus_in = '0;
        in_sample = '0;
        credit = 1'b0;
        reset = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b1;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        repeat (4) @(posedge clock);
        if (i_checker.pending() != 0) begin
            i_checker.report_problem("Expected responses were still pending at the end");
        end
        $display("%0d checks, %0d failures", i_checker.checks, i_checker.failures);
        if (i_checker.failures == 0 && lines.size() != 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Twenty cycles per stimulus line
    initial begin
        wait (loaded);
        repeat (lines.size() * 20 + 20) @(posedge clock);
        $display("Watchdog expired before the stimulus finished");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- dv/adc_stimulus.txt
# Columns: operation, address or value (hex), write data (hex), expected (hex)
# A dash marks an empty column; a sample with a dash expects no output
write  43C00000 8AD08AD0 -
write  43C00004 8B008B00 -
write  43C00008 75007500 -
write  43C0000C 75307530 -
write  43C00010 02800064 -
write  43C00014 01020021 -
write  43C00020 DEADBEEF -
read   43C00000 - 8AD08AD0
read   43C00004 - 8B008B00
read   43C00008 - 75007500
read   43C0000C - 75307530
read   43C00010 - 02800064
read   43C00014 - 01020021
read   43C00020 - 00000000
sample 03E8 - 055F
sample FC18 - FB9B
sample 0001 - 007E
sample FF35 - FF7F
credit 4 - -
sample 7530 - 7FFF
sample 8AD0 - 8000
sample 03E8 - 055F
credit 3 - -
write  43C00014 03020000 -
sample 0001 - 0065
sample 0002 - -
sample 0003 - -
sample 0004 - 0068
sample 0005 - -
sample 0006 - -
sample 0007 - 006B
sample 0008 - -
sample 0009 - -
sample 000A - 006E
sample 000B - -
sample 000C - -
sample 000D - -
read   43C00018 - 00000002
credit 2 - -
sample 000E - -
sample 000F - -
sample 0010 - 0074
credit 3 - -
write  43C00000 8AD0FC18 -
write  43C00004 8B00FE0C -
write  43C00014 01020000 -
sample FB50 - FBB4
read   43C00018 - 00000004
sample FCE0 - FD44
read   43C00018 - 00000004
sample FED4 - FF38
read   43C00018 - 00000000
credit 3 - -
write  43C00014 01020002 -
sample FB50 - FBB4
read   43C00018 - 00000004
sample 0000 - 0064
read   43C00018 - 00000004
write  43C00014 0102000A -
read   43C00018 - 00000000
credit 2 - -
write  43C00008 05DC7500 -
write  43C0000C 07D07530 -
write  43C00014 01000300 -
sample FB50 - FBB4
read   43C00018 - 00000005
sample 0000 - 0064
read   43C00018 - 00000001
write  43C00014 01010300 -
read   43C00018 - 00000000
credit 2 - -
sample 0960 - 09C4
sample 0960 - 09C4
read   43C00018 - 00000020
credit 2 - -
sample 0960 - 09C4
sample 0960 - 09C4
read   43C00018 - 00000021
credit 2 - -
write  43C00014 01020300 -
sample FB50 - FBB4
read   43C00018 - 00000004

//--- project.f
+incdir+source
source/adc_bus_pkg.sv
source/adc_data_pkg.sv
source/adc_control_unit.sv
source/adc_fault_unit.sv
source/adc_calibrator.sv
source/adc_comparators.sv
source/adc_decimator.sv
source/adc_processing.sv
dv/adc_checker.sv
dv/adc_processing_tb.sv

//--- Makefile
TOP = adc_processing_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) --Mdir build -o sim
	./build/sim | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf build
